// File: tensor_out.f
source/accel_cfg_pkg.sv
source/tensor_data_pkg.sv
source/tensor_ram.sv
source/output_coordinator.sv
source/wb_tensor_regs.sv
source/tensor_out_top.sv
testbench/tb_tensor_out.sv

// File: Makefile
# Verilator build and run for the tensor output subsystem
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_tensor_out
FILELIST  ?= tensor_out.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= ** PASS **

.PHONY: sim clean

# Build, run, then decide the result from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF -- "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed, see $(LOG)"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_tensor_out.sv
`timescale 1ns/100ps

module tb_tensor_out;

    import accel_cfg_pkg::*;
    import tensor_data_pkg::*;

    localparam int DEPTH_WORDS = 128;
    localparam int CAP_BYTES   = DEPTH_WORDS * 16;
    localparam int NUM_JOBS    = 10;

    typedef struct {
        string name;
        int    rows;
        int    cols;
        int    chans;
        int    shift;
        bit    extreme;                                  // Boundary accumulators, not random
        bit    exp_err;                                  // Must be rejected at start
    } job_t;

    logic                   clk;
    logic                   rst_n;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [WB_ADR_BITS-1:0] wb_adr;
    logic [31:0]            wb_dat_w;
    logic                   wb_ack;
    logic [31:0]            wb_dat_r;
    result_beat_t           result_beat;
    logic                   result_valid;
    logic                   result_ready;

    job_t        jobs [NUM_JOBS];
    logic [7:0]  model_mem [CAP_BYTES];                  // Expected tensor RAM contents
    logic [31:0] rng = 32'h8430_9cd0;
    int          hi_bytes = 0;                           // Bytes written so far by any job
    int          error_count = 0;
    int          tests_ok = 0;
    int          tests_bad = 0;
    int          cycles = 0;
    int          cycle_limit;

    tensor_out_top #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) UUT (
        .clk           (clk)
        ,.rst_n        (rst_n)
        ,.wb_cyc       (wb_cyc)
        ,.wb_stb       (wb_stb)
        ,.wb_we        (wb_we)
        ,.wb_adr       (wb_adr)
        ,.wb_dat_w     (wb_dat_w)
        ,.wb_ack       (wb_ack)
        ,.wb_dat_r     (wb_dat_r)
        ,.result_beat  (result_beat)
        ,.result_valid (result_valid)
        ,.result_ready (result_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                          // 20 ns period
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: run still going after %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Shift right by sh with floor rounding, then clamp to int8
    function automatic logic [7:0] requant(input logic signed [31:0] acc, input int sh);
        longint v;
        v = longint'(acc) >>> sh;
        if (v > 127) v = 127;
        else if (v < -128) v = -128;
        return v[7:0];
    endfunction

    // Accumulators around the clamp limits for a given shift
    function automatic logic signed [31:0] extreme_acc(input int idx, input int sh);
        int step;
        step = 1 << sh;
        case (idx % 8)
            0: return 32'sh7FFF_FFFF;
            1: return 32'sh8000_0000;
            2: return 128 * step - 1;                    // Largest that lands on 127
            3: return 128 * step;                        // Just over, clamps
            4: return -128 * step;                       // Smallest kept as is
            5: return -128 * step - 1;                   // Floors to -129
            6: return -1;
            default: return ((idx % 200) - 100) * step;  // Mid range
        endcase
    endfunction

    // Per job: 4 cycles per beat plus 8 per lane read back, then a fixed margin
    function automatic int compute_limit();
        int sum;
        int hi;
        int n;
        sum = 2000;
        hi  = 0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            n = jobs[j].rows * jobs[j].cols * jobs[j].chans;
            if (!jobs[j].exp_err) begin
                sum += n * 4;
                if (n > hi) hi = n;
            end
            sum += ((hi + 3) / 4) * 8;
        end
        return sum;
    endfunction

    task automatic report_mismatch(input string tag, input logic [31:0] exp, act);
        $display("** Error %s: expected %h, actual %h", tag, exp, act);
        error_count++;
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            tests_ok++;
            $display("test %-14s ok", name);
        end else begin
            tests_bad++;
            $display("test %-14s bad, %0d errors", name, error_count - errs_before);
        end
    endtask

    // Wishbone classic, driven on the falling edge
    // cyc and stb stay up through the rising edge that samples ack
    task automatic wb_write(input logic [WB_ADR_BITS-1:0] adr, input logic [31:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        do begin
            @(negedge clk);
        end while (!wb_ack);
        @(negedge clk);                                  // Ack edge has passed
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        @(negedge clk);                                  // One idle cycle between transfers
    endtask

    task automatic wb_read(input logic [WB_ADR_BITS-1:0] adr, output logic [31:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        do begin
            @(negedge clk);
        end while (!wb_ack);
        data = wb_dat_r;
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        @(negedge clk);
    endtask

    // Feeds one job in row, column, channel order and fills the model
    task automatic stream_job(input job_t jb);
        int                 n;
        int                 idx;
        int                 addr;
        logic signed [31:0] acc;
        n   = jb.rows * jb.cols * jb.chans;
        idx = 0;
        for (int r = 0; r < jb.rows; r++) begin
            for (int c = 0; c < jb.cols; c++) begin
                for (int k = 0; k < jb.chans; k++) begin
                    addr = ((r * jb.cols) + c) * jb.chans + k;
                    if (jb.extreme) begin
                        acc = extreme_acc(idx, jb.shift);
                    end else begin
                        rng = xorshift32(rng);
                        acc = $signed(rng) >>> (8 + rng[3:0]);   // Mixed magnitudes
                    end
                    model_mem[addr] = requant(acc, jb.shift);
                    rng = xorshift32(rng);
                    if (rng[1:0] == 2'b00) begin
                        result_valid = 1'b0;             // Source bubble
                        @(negedge clk);
                    end
                    result_beat.acc  = acc;
                    result_beat.last = (idx == n - 1);
                    result_valid     = 1'b1;
                    while (!result_ready) @(negedge clk);
                    @(negedge clk);                      // Taken on the edge just passed
                    idx++;
                end
            end
        end
        result_valid = 1'b0;
    endtask

    task automatic poll_done(input string name, output logic [31:0] st);
        int          polls;
        job_status_t sts;
        polls = 0;
        do begin
            wb_read({1'b0, REG_STATUS}, st);
            sts = job_status_t'(st[18:0]);
            polls++;
        end while (!sts.done && polls < 100);
        if (!sts.done) begin
            $display("Done flag never rose for test %s", name);
            error_count++;
        end
    endtask

    // Every lane that holds a written byte, compared byte by byte
    task automatic readback(input string name);
        logic [31:0] lane;
        int          a;
        for (int l = 0; l < (hi_bytes + 3) / 4; l++) begin
            wb_read({1'b1, 9'(l)}, lane);
            for (int j = 0; j < 4; j++) begin
                a = 4 * l + j;
                if (a < hi_bytes && lane[8*j +: 8] !== model_mem[a]) begin
                    report_mismatch($sformatf("%s byte %0d", name, a),
                                    32'(model_mem[a]), 32'(lane[8*j +: 8]));
                end
            end
        end
    endtask

    task automatic check_registers();
        logic [31:0] rd;
        wb_write({1'b0, REG_DIMS}, 32'hA512_3456);
        wb_write({1'b0, REG_SHIFT}, 32'hFFFF_FFF3);
        wb_read({1'b0, REG_DIMS}, rd);
        if (rd !== 32'h0012_3456) report_mismatch("reg_access DIMS", 32'h0012_3456, rd);
        wb_read({1'b0, REG_SHIFT}, rd);
        if (rd !== 32'h13) report_mismatch("reg_access SHIFT", 32'h13, rd);
        wb_read(10'h005, rd);
        if (rd !== 32'h0) report_mismatch("reg_access unmapped 0x005", 32'h0, rd);
        wb_read(10'h1FF, rd);
        if (rd !== 32'h0) report_mismatch("reg_access unmapped 0x1ff", 32'h0, rd);
        wb_read({1'b0, REG_CTRL}, rd);
        if (rd !== 32'h0) report_mismatch("reg_access CTRL", 32'h0, rd);
        // A beat offered before any start must wait
        result_beat.acc  = 32'sd77;
        result_beat.last = 1'b0;
        result_valid     = 1'b1;
        repeat (8) begin
            @(negedge clk);
            if (result_ready !== 1'b0) begin
                $display("Stream took a beat before any job was started");
                error_count++;
            end
        end
        wb_read({1'b0, REG_STATUS}, rd);
        if (rd !== 32'h0) report_mismatch("reg_access STATUS", 32'h0, rd);
        result_valid = 1'b0;
    endtask

    task automatic run_job(input job_t jb);
        logic [31:0] st;
        logic [31:0] exp_st;
        int          errs;
        int          n;
        errs = error_count;
        n    = jb.rows * jb.cols * jb.chans;
        wb_write({1'b0, REG_DIMS}, {8'd0, 8'(jb.chans), 8'(jb.cols), 8'(jb.rows)});
        wb_write({1'b0, REG_SHIFT}, 32'(jb.shift));
        wb_write({1'b0, REG_CTRL}, 32'd1);
        if (!jb.exp_err) begin
            stream_job(jb);
            if (n > hi_bytes) hi_bytes = n;
        end
        poll_done(jb.name, st);
        // Busy low, done high, err as expected, written zero on rejection
        exp_st = {13'd0, 1'b0, 1'b1, jb.exp_err, jb.exp_err ? 16'd0 : 16'(n)};
        if (st !== exp_st) report_mismatch({jb.name, " status"}, exp_st, st);
        readback(jb.name);
        report_test(jb.name, errs);
    endtask

    initial begin
        int errs;
        rst_n        = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        result_beat  = '0;
        result_valid = 1'b0;
        //          name            rows cols ch  sh  ext   err
        jobs[0] = '{"place_4x4x8",   4,   4,  8,  2, 1'b0, 1'b0};
        jobs[1] = '{"place_3x5x7",   3,   5,  7,  4, 1'b0, 1'b0};
        jobs[2] = '{"place_1x9x3",   1,   9,  3,  0, 1'b0, 1'b0};
        jobs[3] = '{"sat_shift0",    4,   4,  4,  0, 1'b1, 1'b0};
        jobs[4] = '{"sat_shift8",    2,   8,  4,  8, 1'b1, 1'b0};
        jobs[5] = '{"sat_shift20",   1,   4, 16, 20, 1'b1, 1'b0};
        jobs[6] = '{"full_cap",     16,  16,  8,  6, 1'b0, 1'b0};   // Exactly fills the RAM
        jobs[7] = '{"cap_too_big",  16,  16,  9,  0, 1'b0, 1'b1};
        jobs[8] = '{"cap_zero_dim",  4,   0,  4,  0, 1'b0, 1'b1};
        jobs[9] = '{"small_over",    2,   3,  5,  1, 1'b0, 1'b0};   // Over the full job
        cycle_limit = compute_limit();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        errs = error_count;
        check_registers();
        report_test("reg_access", errs);
        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(jobs[j]);
        end
        $display("Summary: %0d tests ok, %0d tests bad, %0d errors",
                 tests_ok, tests_bad, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: source/tensor_out_top.sv
`timescale 1ns/100ps

// Output side of the accelerator
// Host slave, output coordinator and tensor RAM
module tensor_out_top #(
    parameter int DEPTH_WORDS = 128                          // RAM depth in 128-bit words
) (
    input  logic                                      clk
    ,input  logic                                     rst_n
    ,input  logic                                     wb_cyc
    ,input  logic                                     wb_stb
    ,input  logic                                     wb_we
    ,input  logic [accel_cfg_pkg::WB_ADR_BITS-1:0]    wb_adr
    ,input  logic [accel_cfg_pkg::WB_DAT_BITS-1:0]    wb_dat_w
    ,output logic                                     wb_ack
    ,output logic [accel_cfg_pkg::WB_DAT_BITS-1:0]    wb_dat_r
    ,input  tensor_data_pkg::result_beat_t            result_beat
    ,input  logic                                     result_valid
    ,output logic                                     result_ready
);

    import accel_cfg_pkg::*;
    import tensor_data_pkg::*;

    job_cfg_t                       cfg;                     // Slave to coordinator
    logic                           start;
    job_status_t                    status;                  // Coordinator back to slave
    byte_write_t                    wr;                      // Coordinator to RAM
    logic                           wr_en;
    logic [$clog2(DEPTH_WORDS)-1:0] rd_addr;                 // Slave to RAM
    logic                           rd_en;
    tensor_word_u                   rd_word;

    wb_tensor_regs #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) u_regs (
        .clk         (clk)
        ,.rst_n      (rst_n)
        ,.wb_cyc     (wb_cyc)
        ,.wb_stb     (wb_stb)
        ,.wb_we      (wb_we)
        ,.wb_adr     (wb_adr)
        ,.wb_dat_w   (wb_dat_w)
        ,.wb_ack     (wb_ack)
        ,.wb_dat_r   (wb_dat_r)
        ,.cfg        (cfg)
        ,.start      (start)
        ,.status     (status)
        ,.rd_addr    (rd_addr)
        ,.rd_en      (rd_en)
        ,.rd_word    (rd_word)
    );

    output_coordinator #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) u_coord (
        .clk           (clk)
        ,.rst_n        (rst_n)
        ,.cfg          (cfg)
        ,.start        (start)
        ,.status       (status)
        ,.result_beat  (result_beat)
        ,.result_valid (result_valid)
        ,.result_ready (result_ready)
        ,.wr           (wr)
        ,.wr_en        (wr_en)
    );

    tensor_ram #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) u_ram (
        .clk       (clk)
        ,.wr       (wr)
        ,.wr_en    (wr_en)
        ,.rd_addr  (rd_addr)
        ,.rd_en    (rd_en)
        ,.rd_word  (rd_word)
    );

endmodule

// File: source/wb_tensor_regs.sv
`timescale 1ns/100ps

// Wishbone classic slave
// Control and status registers in the low half of the address space,
// RAM read window in the high half
module wb_tensor_regs #(
    parameter int DEPTH_WORDS = 128                          // RAM depth in 128-bit words
) (
    input  logic                                      clk
    ,input  logic                                     rst_n
    ,input  logic                                     wb_cyc
    ,input  logic                                     wb_stb
    ,input  logic                                     wb_we
    ,input  logic [accel_cfg_pkg::WB_ADR_BITS-1:0]    wb_adr  // Word address
    ,input  logic [accel_cfg_pkg::WB_DAT_BITS-1:0]    wb_dat_w
    ,output logic                                     wb_ack
    ,output logic [accel_cfg_pkg::WB_DAT_BITS-1:0]    wb_dat_r
    ,output accel_cfg_pkg::job_cfg_t                  cfg
    ,output logic                                     start
    ,input  accel_cfg_pkg::job_status_t               status
    ,output logic [$clog2(DEPTH_WORDS)-1:0]           rd_addr
    ,output logic                                     rd_en
    ,input  tensor_data_pkg::tensor_word_u            rd_word
);

    import accel_cfg_pkg::*;

    localparam int WORD_BITS = $clog2(DEPTH_WORDS);

    logic       req;                                         // New transfer waiting for service
    logic       win_sel;
    logic       win_rd;                                      // Request is a window read
    logic [8:0] reg_off;
    logic [1:0] lane_sel;
    logic [1:0] win_cnt;                                     // Window read in flight when nonzero

    // Address decode
    assign win_sel  = wb_adr[WIN_SEL_BIT];
    assign reg_off  = wb_adr[8:0];
    assign lane_sel = wb_adr[1:0];
    assign rd_addr  = wb_adr[2 +: WORD_BITS];                // Master holds adr until ack

    // No new request while acking or while a window read is still running
    assign req    = wb_cyc && wb_stb && !wb_ack && (win_cnt == 2'd0);
    assign win_rd = req && win_sel && !wb_we;

    // Window read sequence
    // cnt 3 issues rd_en, cnt 2 sets ack for the cycle the RAM word is valid
    assign rd_en = (win_cnt == 2'd3);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack  <= 1'b0;
            win_cnt <= 2'd0;
        end else begin
            wb_ack <= (req && !win_rd) || (win_cnt == 2'd2);  // Registers and writes ack next cycle
            if (win_rd) begin
                win_cnt <= 2'd3;
            end else if (win_cnt != 2'd0) begin
                win_cnt <= win_cnt - 2'd1;
            end
        end
    end

    // Register writes
    // Window and unmapped writes fall through and are dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg   <= '0;
            start <= 1'b0;
        end else begin
            start <= req && wb_we && !win_sel && (reg_off == REG_CTRL) &&
                     wb_dat_w[CTRL_START_BIT];               // One cycle pulse
            if (req && wb_we && !win_sel) begin
                case (reg_off)
                    REG_DIMS:  cfg.dims  <= wb_dat_w[23:0];
                    REG_SHIFT: cfg.shift <= wb_dat_w[4:0];
                    default: ;
                endcase
            end
        end
    end

    // Read data
    // Sampled by the master only while ack is high
    always_comb begin
        wb_dat_r = '0;                                       // Unmapped and CTRL read as zero
        if (win_sel) begin
            wb_dat_r = rd_word.lanes[lane_sel];
        end else begin
            case (reg_off)
                REG_DIMS:   wb_dat_r = 32'(cfg.dims);
                REG_SHIFT:  wb_dat_r = 32'(cfg.shift);
                REG_STATUS: wb_dat_r = 32'(status);
                default: ;
            endcase
        end
    end

    // The master keeps cyc and stb up until it sees ack
    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) wb_ack |-> (wb_cyc && wb_stb)
    );

endmodule

// File: source/output_coordinator.sv
`timescale 1ns/100ps

// Output job sequencer
// Takes accumulators off the result stream, requantizes them to int8 and
// turns each one into a byte write at its row/column/channel position
module output_coordinator #(
    parameter int DEPTH_WORDS = 128                          // RAM depth in 128-bit words
) (
    input  logic                                 clk
    ,input  logic                                rst_n
    ,input  accel_cfg_pkg::job_cfg_t             cfg         // Live register values
    ,input  logic                                start       // One cycle pulse from the host
    ,output accel_cfg_pkg::job_status_t          status
    ,input  tensor_data_pkg::result_beat_t       result_beat
    ,input  logic                                result_valid
    ,output logic                                result_ready
    ,output tensor_data_pkg::byte_write_t        wr
    ,output logic                                wr_en
);

    import accel_cfg_pkg::*;
    import tensor_data_pkg::*;

    localparam int CAP_BYTES = DEPTH_WORDS * BYTES_PER_WORD;

    job_cfg_t                  job_q;                        // Configuration frozen at start
    logic [7:0]                row_q;
    logic [7:0]                col_q;
    logic [7:0]                ch_q;
    logic [BYTE_ADDR_BITS-1:0] addr_q;                       // Running byte address
    logic                      final_q;                      // Last element taken, write pending
    logic [23:0]               job_elems;
    logic                      cap_bad;
    logic                      launch;
    logic                      beat_fire;
    logic                      last_elem;
    acc_t                      shifted;
    int8_t                     q_val;

    // Capacity check on the programmed shape
    assign job_elems = 24'(cfg.dims.rows) * 24'(cfg.dims.cols) * 24'(cfg.dims.channels);
    assign cap_bad   = (job_elems == 24'd0) || (32'(job_elems) > CAP_BYTES);
    assign launch    = start && !status.busy;                // Start is ignored mid job

    assign result_ready = status.busy && !final_q;           // Close the stream once the last beat is in
    assign beat_fire    = result_valid && result_ready;

    assign last_elem = (ch_q  == job_q.dims.channels - 8'd1) &&
                       (col_q == job_q.dims.cols - 8'd1) &&
                       (row_q == job_q.dims.rows - 8'd1);

    // Requantize
    // Arithmetic shift, then clamp to the int8 range
    always_comb begin
        shifted = result_beat.acc >>> job_q.shift;
        if (shifted > 32'sd127) begin
            q_val = 8'sd127;
        end else if (shifted < -32'sd128) begin
            q_val = -8'sd128;
        end else begin
            q_val = shifted[7:0];
        end
    end

    // Job control and status
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status  <= '0;
            wr_en   <= 1'b0;
            final_q <= 1'b0;
        end else begin
            wr_en <= beat_fire;                              // Write one cycle after acceptance
            if (wr_en) begin
                status.written <= status.written + 16'd1;
            end
            if (launch) begin
                status.written <= '0;
                if (cap_bad) begin
                    status.err  <= 1'b1;                     // Rejected, busy stays low
                    status.done <= 1'b1;
                end else begin
                    status.busy <= 1'b1;
                    status.done <= 1'b0;
                    status.err  <= 1'b0;
                end
            end
            if (beat_fire && last_elem) begin
                final_q <= 1'b1;
            end
            // Final byte is being written this cycle
            if (final_q && wr_en) begin
                status.busy <= 1'b0;
                status.done <= 1'b1;
                final_q     <= 1'b0;
            end
        end
    end

    // Counters and write register
    // Channel-last row-major order makes the byte address simply the element
    // index, so the address steps by one per beat and no multiply is needed
    always_ff @(posedge clk) begin
        if (launch) begin
            job_q  <= cfg;
            row_q  <= '0;
            col_q  <= '0;
            ch_q   <= '0;
            addr_q <= '0;
        end else if (beat_fire) begin
            addr_q <= addr_q + 1'b1;
            if (ch_q == job_q.dims.channels - 8'd1) begin
                ch_q <= '0;
                if (col_q == job_q.dims.cols - 8'd1) begin
                    col_q <= '0;
                    row_q <= row_q + 8'd1;                   // Next row
                end else begin
                    col_q <= col_q + 8'd1;
                end
            end else begin
                ch_q <= ch_q + 8'd1;
            end
        end
        if (beat_fire) begin
            wr.addr <= addr_q;
            wr.data <= q_val;
        end
    end

    // Outside a job the stream is closed and no write is left in flight
    a_ready_only_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
            !status.busy |-> (!result_ready && !wr_en && !final_q)
    );

    // Shape was checked at start, so no write may run past the RAM
    a_wr_in_capacity: assert property (
        @(posedge clk) disable iff (!rst_n) wr_en |-> (32'(wr.addr) < CAP_BYTES)
    );

endmodule

// File: source/tensor_ram.sv
`timescale 1ns/100ps

// Byte-banked tensor store
// Sixteen 8-bit banks share one word index, so a single byte write touches
// one bank while a read pulls the same row out of all banks at once
module tensor_ram #(
    parameter int DEPTH_WORDS = 128                          // Depth in 128-bit words
) (
    input  logic                                 clk
    ,input  tensor_data_pkg::byte_write_t        wr          // Byte address and data
    ,input  logic                                wr_en
    ,input  logic [$clog2(DEPTH_WORDS)-1:0]      rd_addr     // Word index
    ,input  logic                                rd_en
    ,output tensor_data_pkg::tensor_word_u       rd_word     // Valid 2 cycles after rd_en
);

    import tensor_data_pkg::*;

    localparam int WORD_BITS = $clog2(DEPTH_WORDS);

    logic [BANK_SEL_BITS-1:0] wr_bank;                       // Which bank takes the byte
    logic [WORD_BITS-1:0]     wr_word;                       // Row inside that bank
    int8_t                    bank_q [BYTES_PER_WORD];       // First read stage, one per bank

    // Byte address split
    // addr = word * 16 + bank
    assign wr_bank = wr.addr[BANK_SEL_BITS-1:0];
    assign wr_word = wr.addr[BANK_SEL_BITS +: WORD_BITS];

    for (genvar b = 0; b < BYTES_PER_WORD; b++) begin : g_bank
        int8_t mem [DEPTH_WORDS];                            // Storage for byte lane b

        always_ff @(posedge clk) begin
            if (wr_en && (wr_bank == BANK_SEL_BITS'(b))) begin
                mem[wr_word] <= wr.data;
            end
            // Bank output register, holds until the next read
            if (rd_en) begin
                bank_q[b] <= mem[rd_addr];
            end
        end
    end

    // Second stage
    // Bank b lands in byte b of the word, the host sees it through the lanes view
    always_ff @(posedge clk) begin
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            rd_word.bytes[b] <= bank_q[b];
        end
    end

    // The slave derives rd_addr from the bus address, so a stray window
    // address must never reach the banks
    a_rd_addr_in_range: assert property (
        @(posedge clk) rd_en |-> (rd_addr < DEPTH_WORDS)
    );

endmodule

// File: source/tensor_data_pkg.sv
package tensor_data_pkg;

    typedef logic signed [7:0]  int8_t;      // Requantized element
    typedef logic signed [31:0] acc_t;       // Raw accumulator from the array

    // RAM word geometry
    localparam int BYTES_PER_WORD = 16;
    localparam int LANES_PER_WORD = 4;
    localparam int BANK_SEL_BITS  = 4;       // Low byte address bits pick the bank
    localparam int BYTE_ADDR_BITS = 16;

    // One beat of the result stream
    typedef struct packed {
        acc_t acc;
        logic last;                          // End marker from the array
    } result_beat_t;

    // Single byte store into the tensor RAM
    typedef struct packed {
        logic [BYTE_ADDR_BITS-1:0] addr;     // Byte address, row major and channel last
        int8_t                     data;
    } byte_write_t;

    // The coordinator fills a word byte by byte, the host reads it back in 32-bit lanes
    // Byte i sits at bits 8i and up, lane i at bits 32i and up
    typedef union packed {
        int8_t [BYTES_PER_WORD-1:0]              bytes;
        logic  [LANES_PER_WORD-1:0][31:0]        lanes;
    } tensor_word_u;

endpackage

// File: source/accel_cfg_pkg.sv
package accel_cfg_pkg;

    // Wishbone bus geometry
    localparam int WB_ADR_BITS = 10;
    localparam int WB_DAT_BITS = 32;
    localparam int WIN_SEL_BIT = 9;          // Upper half of the address space is the RAM window

    // Register word offsets on wb_adr[8:0]
    localparam logic [8:0] REG_CTRL   = 9'd0; // Write only, reads as zero
    localparam logic [8:0] REG_DIMS   = 9'd1;
    localparam logic [8:0] REG_SHIFT  = 9'd2;
    localparam logic [8:0] REG_STATUS = 9'd3; // Read only

    localparam int CTRL_START_BIT = 0;       // Writing 1 here launches a job

    // Job dimensions, laid out exactly as the DIMS register
    typedef struct packed {
        logic [7:0] channels;                // Bits 23:16
        logic [7:0] cols;                    // Bits 15:8
        logic [7:0] rows;                    // Bits 7:0
    } dims_t;

    typedef struct packed {
        dims_t      dims;
        logic [4:0] shift;                   // Arithmetic right shift before saturation
    } job_cfg_t;

    // STATUS word is this struct zero extended to 32 bits
    // busy at bit 18, done at 17, err at 16, written in 15:0
    typedef struct packed {
        logic        busy;
        logic        done;
        logic        err;                    // Job rejected at start
        logic [15:0] written;                // Elements stored by the current or last job
    } job_status_t;

endpackage
